// File: source/frontend_pkg.sv
// shared front-end constants and types; widths assume FETCH_W and DECODE_W of 2, XLEN of 32
package frontend_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int unsigned FETCH_W    = 2;
  localparam int unsigned DECODE_W   = 2;
  localparam int unsigned IBUF_DEPTH = 8;
  localparam int unsigned XLEN       = 32;
  localparam int unsigned OP_W       = 6;
  localparam int unsigned REG_W      = 5;
  localparam int unsigned CSR_NUM_W  = 14;

  // lane count, buffer pointer and occupancy widths
  localparam int unsigned WCNT_W     = $clog2(FETCH_W + 1);
  localparam int unsigned IBUF_PTR_W = $clog2(IBUF_DEPTH);
  localparam int unsigned IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);

  localparam logic [XLEN-1:0]  RESET_PC = 32'h1c00_0000;
  localparam logic [REG_W-1:0] RA_REG   = 5'd1;

  // ==================================================
  // major opcodes, instruction bits 31:26
  // ==================================================
  localparam logic [OP_W-1:0] OP_ALU_REG = 6'b000000;
  localparam logic [OP_W-1:0] OP_CSR     = 6'b000001;
  localparam logic [OP_W-1:0] OP_ALU_IMM = 6'b000010;
  localparam logic [OP_W-1:0] OP_LOAD    = 6'b001010;
  localparam logic [OP_W-1:0] OP_STORE   = 6'b001011;
  localparam logic [OP_W-1:0] OP_BL      = 6'b010101;
  localparam logic [OP_W-1:0] OP_BRANCH  = 6'b010110;

  typedef enum logic [2:0] {
    CLS_ALU    = 3'd0,
    CLS_ALUI   = 3'd1,
    CLS_BRANCH = 3'd2,
    CLS_CALL   = 3'd3,
    CLS_CSR    = 3'd4,
    CLS_LOAD   = 3'd5,
    CLS_STORE  = 3'd6,
    CLS_NONE   = 3'd7
  } class_e;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_READ  = 2'd1,
    CSR_WRITE = 2'd2,
    CSR_XCHG  = 2'd3
  } csr_op_e;

  // one instruction word, seen as register form or CSR form
  typedef union packed {
    struct packed {
      logic [OP_W-1:0]  opcode;
      logic [10:0]      unused;
      logic [REG_W-1:0] rk;
      logic [REG_W-1:0] rj;
      logic [REG_W-1:0] rd;
    } r;
    struct packed {
      logic [OP_W-1:0]      opcode;
      logic [1:0]           unused;
      logic [CSR_NUM_W-1:0] csr_num;
      logic [REG_W-1:0]     rj;
      logic [REG_W-1:0]     rd;
    } c;
  } instr_word_u;

endpackage

// File: source/redirect_ctrl.sv
// commit-driven flush and target select; at most one commit per cycle, tlbr must come with excp
`timescale 1ns/1ps

module redirect_ctrl
  import frontend_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            cmt_valid_i,
  input  logic            cmt_excp_i,
  input  logic            cmt_tlbr_i,
  input  logic            cmt_redirect_i,
  input  logic            cmt_ertn_i,
  input  logic            cmt_refetch_i,
  input  logic            cmt_idle_i,
  input  logic [XLEN-1:0] cmt_pc_i,
  input  logic [XLEN-1:0] cmt_br_target_i,
  input  logic [XLEN-1:0] eentry_i,
  input  logic [XLEN-1:0] tlbrentry_i,
  input  logic [XLEN-1:0] era_i,
  input  logic            has_int_i,
  output logic            flush_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output logic            fetch_enable_o
);

  logic tlbr_c;
  logic excp_c;
  logic redirect_c;
  logic ertn_c;
  logic refetch_c;
  logic idle_lock;

  assign tlbr_c     = cmt_valid_i & cmt_tlbr_i;
  assign excp_c     = cmt_valid_i & cmt_excp_i;
  assign redirect_c = cmt_valid_i & cmt_redirect_i;
  assign ertn_c     = cmt_valid_i & cmt_ertn_i;
  // idle restarts after itself, like any refetch
  assign refetch_c  = cmt_valid_i & (cmt_refetch_i | cmt_idle_i);

  assign flush_o = tlbr_c | excp_c | redirect_c | ertn_c | refetch_c;

  // fixed priority, tlb refill entry first
  assign redirect_pc_o = tlbr_c     ? tlbrentry_i :
                         excp_c     ? eentry_i :
                         redirect_c ? cmt_br_target_i :
                         ertn_c     ? era_i :
                         refetch_c  ? cmt_pc_i + XLEN'(4) :
                         RESET_PC;

  // hold fetch after idle until an interrupt is pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (cmt_valid_i && cmt_idle_i && !has_int_i) begin
      idle_lock <= 1'b1;
    end else if (has_int_i) begin
      idle_lock <= 1'b0;
    end
  end

  assign fetch_enable_o = ~idle_lock;

  a_tlbr_implies_excp: assert property (
    @(posedge clk) disable iff (!rst_n) (cmt_valid_i && cmt_tlbr_i) |-> cmt_excp_i
  );

endmodule

// File: source/fetch_compactor.sv
// one-entry fetch-packet stage; lane k has pc + 4k, packets seen during flush are dropped
`timescale 1ns/1ps

module fetch_compactor
  import frontend_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          fetch_valid_i,
  input  logic [FETCH_W-1:0]            fetch_lane_valid_i,
  input  logic [XLEN-1:0]               fetch_pc_i,
  input  logic [FETCH_W-1:0][XLEN-1:0]  fetch_instr_i,
  output logic                          fetch_ready_o,
  input  logic                          wr_ready_i,
  output logic [WCNT_W-1:0]             wr_count_o,
  output logic [FETCH_W-1:0][XLEN-1:0]  wr_pc_o,
  output logic [FETCH_W-1:0][XLEN-1:0]  wr_instr_o
);

  logic                         stage_valid;
  logic [FETCH_W-1:0]           stage_lane_valid;
  logic [XLEN-1:0]              stage_pc;
  logic [FETCH_W-1:0][XLEN-1:0] stage_instr;
  logic                         accept;

  // stage drains into the buffer whenever it has room
  assign fetch_ready_o = !stage_valid || wr_ready_i;
  assign accept        = fetch_valid_i && fetch_ready_o && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else if (flush_i) begin
      stage_valid <= 1'b0;
    end else if (fetch_ready_o) begin
      stage_valid <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage_lane_valid <= fetch_lane_valid_i;
      stage_pc         <= fetch_pc_i;
      stage_instr      <= fetch_instr_i;
    end
  end

  // pack valid lanes down to lane 0, keeping fetch order
  always_comb begin : pack_lanes
    logic [WCNT_W-1:0] n;
    n          = '0;
    wr_pc_o    = '0;
    wr_instr_o = '0;
    for (int k = 0; k < FETCH_W; k++) begin
      if (stage_valid && stage_lane_valid[k]) begin
        wr_pc_o[n]    = stage_pc + XLEN'(4 * k);
        wr_instr_o[n] = stage_instr[k];
        n             = n + 1'b1;
      end
    end
    wr_count_o = n;
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n) wr_count_o <= WCNT_W'(FETCH_W)
  );

endmodule

// File: source/instr_buffer.sv
// circular instruction FIFO; accepts FETCH_W lanes only when that many slots are free
`timescale 1ns/1ps

module instr_buffer
  import frontend_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic [WCNT_W-1:0]             wr_count_i,
  input  logic [FETCH_W-1:0][XLEN-1:0]  wr_pc_i,
  input  logic [FETCH_W-1:0][XLEN-1:0]  wr_instr_i,
  output logic                          wr_ready_o,
  input  logic                          rd_ready_i,
  output logic [DECODE_W-1:0]           rd_valid_o,
  output logic [DECODE_W-1:0][XLEN-1:0] rd_pc_o,
  output logic [DECODE_W-1:0][XLEN-1:0] rd_instr_o
);

  logic [XLEN-1:0]       mem_pc    [IBUF_DEPTH];
  logic [XLEN-1:0]       mem_instr [IBUF_DEPTH];
  logic [IBUF_PTR_W-1:0] rd_ptr;
  logic [IBUF_PTR_W-1:0] wr_ptr;
  logic [IBUF_CNT_W-1:0] count;
  logic [IBUF_CNT_W-1:0] push_cnt;
  logic [IBUF_CNT_W-1:0] pop_cnt;

  assign wr_ready_o = (IBUF_CNT_W'(IBUF_DEPTH) - count) >= IBUF_CNT_W'(FETCH_W);
  assign push_cnt   = wr_ready_o ? IBUF_CNT_W'(wr_count_i) : '0;

  // every valid head lane leaves together
  always_comb begin
    pop_cnt = '0;
    if (rd_ready_i) begin
      pop_cnt = (count >= IBUF_CNT_W'(DECODE_W)) ? IBUF_CNT_W'(DECODE_W) : count;
    end
  end

  // ==================================================
  // read ports, oldest entries first
  // ==================================================
  always_comb begin : read_ports
    logic [IBUF_PTR_W-1:0] idx;
    for (int k = 0; k < DECODE_W; k++) begin
      idx           = rd_ptr + IBUF_PTR_W'(k);
      rd_valid_o[k] = count > IBUF_CNT_W'(k);
      rd_pc_o[k]    = mem_pc[idx];
      rd_instr_o[k] = mem_instr[idx];
    end
  end

  // ==================================================
  // write ports and pointers
  // ==================================================
  always_ff @(posedge clk) begin
    for (int k = 0; k < FETCH_W; k++) begin
      if (IBUF_CNT_W'(k) < push_cnt) begin
        mem_pc[wr_ptr + IBUF_PTR_W'(k)]    <= wr_pc_i[k];
        mem_instr[wr_ptr + IBUF_PTR_W'(k)] <= wr_instr_i[k];
      end
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + IBUF_PTR_W'(push_cnt);
      rd_ptr <= rd_ptr + IBUF_PTR_W'(pop_cnt);
      count  <= count + push_cnt - pop_cnt;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) count <= IBUF_CNT_W'(IBUF_DEPTH)
  );

endmodule

// File: source/instr_decoder.sv
// combinational per-lane decode over the small major-opcode table; register 0 means unused
`timescale 1ns/1ps

module instr_decoder
  import frontend_pkg::*;
(
  input  logic [DECODE_W-1:0]                rd_valid_i,
  input  logic [DECODE_W-1:0][XLEN-1:0]      rd_pc_i,
  input  instr_word_u [DECODE_W-1:0]         rd_instr_i,
  output logic [DECODE_W-1:0]                dec_valid_o,
  output logic [DECODE_W-1:0][XLEN-1:0]      dec_pc_o,
  output class_e [DECODE_W-1:0]              dec_class_o,
  output logic [DECODE_W-1:0][REG_W-1:0]     dec_src0_o,
  output logic [DECODE_W-1:0][REG_W-1:0]     dec_src1_o,
  output logic [DECODE_W-1:0][REG_W-1:0]     dec_dest_o,
  output csr_op_e [DECODE_W-1:0]             dec_csr_op_o,
  output logic [DECODE_W-1:0][CSR_NUM_W-1:0] dec_csr_num_o
);

  assign dec_valid_o = rd_valid_i;
  assign dec_pc_o    = rd_pc_i;

  always_comb begin : decode_lanes
    for (int i = 0; i < DECODE_W; i++) begin
      dec_class_o[i]   = CLS_NONE;
      dec_src0_o[i]    = '0;
      dec_src1_o[i]    = '0;
      dec_dest_o[i]    = '0;
      dec_csr_op_o[i]  = CSR_NONE;
      dec_csr_num_o[i] = '0;
      case (rd_instr_i[i].r.opcode)
        OP_ALU_REG: begin
          dec_class_o[i] = CLS_ALU;
          dec_src0_o[i]  = rd_instr_i[i].r.rj;
          dec_src1_o[i]  = rd_instr_i[i].r.rk;
          dec_dest_o[i]  = rd_instr_i[i].r.rd;
        end
        OP_ALU_IMM, OP_LOAD: begin
          dec_class_o[i] = (rd_instr_i[i].r.opcode == OP_LOAD) ? CLS_LOAD : CLS_ALUI;
          dec_src0_o[i]  = rd_instr_i[i].r.rj;
          dec_dest_o[i]  = rd_instr_i[i].r.rd;
        end
        // rd is read, not written, by branches and stores
        OP_BRANCH, OP_STORE: begin
          dec_class_o[i] = (rd_instr_i[i].r.opcode == OP_STORE) ? CLS_STORE : CLS_BRANCH;
          dec_src0_o[i]  = rd_instr_i[i].r.rj;
          dec_src1_o[i]  = rd_instr_i[i].r.rd;
        end
        OP_BL: begin
          dec_class_o[i] = CLS_CALL;
          dec_dest_o[i]  = RA_REG;
        end
        OP_CSR: begin
          dec_class_o[i]   = CLS_CSR;
          dec_csr_num_o[i] = rd_instr_i[i].c.csr_num;
          dec_dest_o[i]    = rd_instr_i[i].c.rd;
          // rj selects read, write or exchange
          case (rd_instr_i[i].c.rj)
            REG_W'(0): dec_csr_op_o[i] = CSR_READ;
            REG_W'(1): begin
              dec_csr_op_o[i] = CSR_WRITE;
              dec_src0_o[i]   = rd_instr_i[i].c.rd;
            end
            default: begin
              dec_csr_op_o[i] = CSR_XCHG;
              dec_src0_o[i]   = rd_instr_i[i].c.rd;
              dec_src1_o[i]   = rd_instr_i[i].c.rj;
            end
          endcase
        end
        default: dec_class_o[i] = CLS_NONE;
      endcase
    end
  end

endmodule

// File: source/frontend_top.sv
// front-end top; fetch to decode latency is 2 edges without back-pressure, flush is same-cycle
`timescale 1ns/1ps

module frontend_top
  import frontend_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  // fetch packet
  input  logic                                fetch_valid_i,
  input  logic [FETCH_W-1:0]                  fetch_lane_valid_i,
  input  logic [XLEN-1:0]                     fetch_pc_i,
  input  logic [FETCH_W-1:0][XLEN-1:0]        fetch_instr_i,
  output logic                                fetch_ready_o,
  // decoded lanes
  input  logic                                dec_ready_i,
  output logic [DECODE_W-1:0]                 dec_valid_o,
  output logic [DECODE_W-1:0][XLEN-1:0]       dec_pc_o,
  output class_e [DECODE_W-1:0]               dec_class_o,
  output logic [DECODE_W-1:0][REG_W-1:0]      dec_src0_o,
  output logic [DECODE_W-1:0][REG_W-1:0]      dec_src1_o,
  output logic [DECODE_W-1:0][REG_W-1:0]      dec_dest_o,
  output csr_op_e [DECODE_W-1:0]              dec_csr_op_o,
  output logic [DECODE_W-1:0][CSR_NUM_W-1:0]  dec_csr_num_o,
  // commit events
  input  logic                                cmt_valid_i,
  input  logic                                cmt_excp_i,
  input  logic                                cmt_tlbr_i,
  input  logic                                cmt_redirect_i,
  input  logic                                cmt_ertn_i,
  input  logic                                cmt_refetch_i,
  input  logic                                cmt_idle_i,
  input  logic [XLEN-1:0]                     cmt_pc_i,
  input  logic [XLEN-1:0]                     cmt_br_target_i,
  input  logic [XLEN-1:0]                     eentry_i,
  input  logic [XLEN-1:0]                     tlbrentry_i,
  input  logic [XLEN-1:0]                     era_i,
  input  logic                                has_int_i,
  output logic                                flush_o,
  output logic [XLEN-1:0]                     redirect_pc_o,
  output logic                                fetch_enable_o
);

  // ==================================================
  // stage to buffer to decoder
  // ==================================================
  logic [WCNT_W-1:0]             wr_count;
  logic [FETCH_W-1:0][XLEN-1:0]  wr_pc;
  logic [FETCH_W-1:0][XLEN-1:0]  wr_instr;
  logic                          wr_ready;
  logic [DECODE_W-1:0]           rd_valid;
  logic [DECODE_W-1:0][XLEN-1:0] rd_pc;
  logic [DECODE_W-1:0][XLEN-1:0] rd_instr;

  redirect_ctrl i_redirect_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmt_valid_i     (cmt_valid_i),
    .cmt_excp_i      (cmt_excp_i),
    .cmt_tlbr_i      (cmt_tlbr_i),
    .cmt_redirect_i  (cmt_redirect_i),
    .cmt_ertn_i      (cmt_ertn_i),
    .cmt_refetch_i   (cmt_refetch_i),
    .cmt_idle_i      (cmt_idle_i),
    .cmt_pc_i        (cmt_pc_i),
    .cmt_br_target_i (cmt_br_target_i),
    .eentry_i        (eentry_i),
    .tlbrentry_i     (tlbrentry_i),
    .era_i           (era_i),
    .has_int_i       (has_int_i),
    .flush_o         (flush_o),
    .redirect_pc_o   (redirect_pc_o),
    .fetch_enable_o  (fetch_enable_o)
  );

  fetch_compactor i_fetch_compactor (
    .clk                (clk),
    .rst_n              (rst_n),
    .flush_i            (flush_o),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_lane_valid_i (fetch_lane_valid_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_ready_o      (fetch_ready_o),
    .wr_ready_i         (wr_ready),
    .wr_count_o         (wr_count),
    .wr_pc_o            (wr_pc),
    .wr_instr_o         (wr_instr)
  );

  instr_buffer i_instr_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_o),
    .wr_count_i (wr_count),
    .wr_pc_i    (wr_pc),
    .wr_instr_i (wr_instr),
    .wr_ready_o (wr_ready),
    .rd_ready_i (dec_ready_i),
    .rd_valid_o (rd_valid),
    .rd_pc_o    (rd_pc),
    .rd_instr_o (rd_instr)
  );

  instr_decoder i_instr_decoder (
    .rd_valid_i    (rd_valid),
    .rd_pc_i       (rd_pc),
    .rd_instr_i    (rd_instr),
    .dec_valid_o   (dec_valid_o),
    .dec_pc_o      (dec_pc_o),
    .dec_class_o   (dec_class_o),
    .dec_src0_o    (dec_src0_o),
    .dec_src1_o    (dec_src1_o),
    .dec_dest_o    (dec_dest_o),
    .dec_csr_op_o  (dec_csr_op_o),
    .dec_csr_num_o (dec_csr_num_o)
  );

endmodule

// File: verification/tb_checker.sv
// reference model of the front end; samples on the rising edge, inputs must change on the falling edge
`timescale 1ns/1ps

module tb_checker
  import frontend_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                fetch_valid_i,
  input  logic [FETCH_W-1:0]                  fetch_lane_valid_i,
  input  logic [XLEN-1:0]                     fetch_pc_i,
  input  logic [FETCH_W-1:0][XLEN-1:0]        fetch_instr_i,
  input  logic                                fetch_ready_i,
  input  logic                                dec_ready_i,
  input  logic [DECODE_W-1:0]                 dec_valid_i,
  input  logic [DECODE_W-1:0][XLEN-1:0]       dec_pc_i,
  input  class_e [DECODE_W-1:0]               dec_class_i,
  input  logic [DECODE_W-1:0][REG_W-1:0]      dec_src0_i,
  input  logic [DECODE_W-1:0][REG_W-1:0]      dec_src1_i,
  input  logic [DECODE_W-1:0][REG_W-1:0]      dec_dest_i,
  input  csr_op_e [DECODE_W-1:0]              dec_csr_op_i,
  input  logic [DECODE_W-1:0][CSR_NUM_W-1:0]  dec_csr_num_i,
  // valid, excp, tlbr, redirect, ertn, refetch, idle
  input  logic [6:0]                          cmt_flags_i,
  input  logic [XLEN-1:0]                     cmt_pc_i,
  input  logic [XLEN-1:0]                     cmt_br_target_i,
  input  logic [XLEN-1:0]                     eentry_i,
  input  logic [XLEN-1:0]                     tlbrentry_i,
  input  logic [XLEN-1:0]                     era_i,
  input  logic                                has_int_i,
  input  logic                                flush_i,
  input  logic [XLEN-1:0]                     redirect_pc_i,
  input  logic                                fetch_enable_i,
  output int                                  errors_o,
  output int                                  pending_o,
  output logic                                stall_seen_o
);

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } lane_t;

  lane_t exp_q[$];
  logic  idle_ref;
  logic  flush_prev;

  // ==================================================
  // reference functions
  // ==================================================
  // {class, src0, src1, dest, csr op, csr number}
  function automatic logic [33:0] decode_ref(input logic [XLEN-1:0] w);
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [13:0] num;
    rk  = w[14:10];
    rj  = w[9:5];
    rd  = w[4:0];
    num = w[23:10];
    case (w[31:26])
      OP_ALU_REG: return {CLS_ALU, rj, rk, rd, CSR_NONE, 14'd0};
      OP_ALU_IMM: return {CLS_ALUI, rj, 5'd0, rd, CSR_NONE, 14'd0};
      OP_BRANCH:  return {CLS_BRANCH, rj, rd, 5'd0, CSR_NONE, 14'd0};
      OP_BL:      return {CLS_CALL, 5'd0, 5'd0, RA_REG, CSR_NONE, 14'd0};
      OP_LOAD:    return {CLS_LOAD, rj, 5'd0, rd, CSR_NONE, 14'd0};
      OP_STORE:   return {CLS_STORE, rj, rd, 5'd0, CSR_NONE, 14'd0};
      OP_CSR: begin
        if (rj == 5'd0) begin
          return {CLS_CSR, 5'd0, 5'd0, rd, CSR_READ, num};
        end
        if (rj == 5'd1) begin
          return {CLS_CSR, rd, 5'd0, rd, CSR_WRITE, num};
        end
        return {CLS_CSR, rd, rj, rd, CSR_XCHG, num};
      end
      default: return {CLS_NONE, 5'd0, 5'd0, 5'd0, CSR_NONE, 14'd0};
    endcase
  endfunction

  // {flush, target}
  function automatic logic [XLEN:0] redirect_ref(input logic [6:0] f);
    if (!f[6]) begin
      return {1'b0, RESET_PC};
    end
    if (f[4]) begin
      return {1'b1, tlbrentry_i};
    end
    if (f[5]) begin
      return {1'b1, eentry_i};
    end
    if (f[3]) begin
      return {1'b1, cmt_br_target_i};
    end
    if (f[2]) begin
      return {1'b1, era_i};
    end
    if (f[1] || f[0]) begin
      return {1'b1, cmt_pc_i + 32'd4};
    end
    return {1'b0, RESET_PC};
  endfunction

  task automatic flag_error(input string msg);
    $display("Fail %0t ns: %s", $time, msg);
    errors_o++;
  endtask

  // ==================================================
  // per-cycle comparison
  // ==================================================
  always @(posedge clk) begin : compare
    lane_t         head;
    logic [XLEN:0] redir_exp;
    logic [33:0]   dec_exp;
    logic [33:0]   dec_got;
    if (!rst_n) begin
      exp_q.delete();
      idle_ref     = 1'b0;
      flush_prev   = 1'b0;
      errors_o     = 0;
      pending_o    = 0;
      stall_seen_o = 1'b0;
    end else begin
      redir_exp = redirect_ref(cmt_flags_i);
      if ({flush_i, redirect_pc_i} !== redir_exp) begin
        flag_error($sformatf("flush/target expected %h got %h", redir_exp,
                             {flush_i, redirect_pc_i}));
      end
      if (fetch_enable_i !== !idle_ref) begin
        flag_error($sformatf("fetch_enable_o expected %b", !idle_ref));
      end
      if (flush_prev && dec_valid_i !== '0) begin
        flag_error("dec_valid_o high in the cycle after a flush");
      end
      if (!fetch_ready_i) begin
        stall_seen_o = 1'b1;
      end
      // with room for a whole packet the buffer cannot block the stage
      if (exp_q.size() <= int'(IBUF_DEPTH - FETCH_W) && fetch_ready_i !== 1'b1) begin
        flag_error($sformatf("fetch_ready_o low with %0d lanes held", exp_q.size()));
      end
      // pops come from the oldest expected lanes
      for (int k = 0; k < DECODE_W; k++) begin
        if (dec_ready_i && dec_valid_i[k]) begin
          if (exp_q.size() == 0) begin
            flag_error($sformatf("lane %0d popped with no lane expected", k));
          end else begin
            head    = exp_q.pop_front();
            dec_exp = decode_ref(head.instr);
            dec_got = {dec_class_i[k], dec_src0_i[k], dec_src1_i[k], dec_dest_i[k],
                       dec_csr_op_i[k], dec_csr_num_i[k]};
            if (dec_pc_i[k] !== head.pc) begin
              flag_error($sformatf("lane %0d pc expected %h got %h", k, head.pc, dec_pc_i[k]));
            end
            if (dec_got !== dec_exp) begin
              flag_error($sformatf("instr %h decode expected %h got %h", head.instr,
                                   dec_exp, dec_got));
            end
          end
        end
      end
      if (flush_i) begin
        exp_q.delete();
      end else if (fetch_valid_i && fetch_ready_i) begin
        for (int k = 0; k < FETCH_W; k++) begin
          if (fetch_lane_valid_i[k]) begin
            exp_q.push_back({fetch_pc_i + XLEN'(4 * k), fetch_instr_i[k]});
          end
        end
      end
      if (cmt_flags_i[6] && cmt_flags_i[0] && !has_int_i) begin
        idle_ref = 1'b1;
      end else if (has_int_i) begin
        idle_ref = 1'b0;
      end
      flush_prev = flush_i;
      pending_o  = exp_q.size();
    end
  end

endmodule

// File: verification/tb_frontend.sv
// testbench top; six directed-random tests, inputs change on the falling edge, fixed cycle limit
`timescale 1ns/1ps

module tb_frontend
  import frontend_pkg::*;
();

  localparam int LEN_ORDER   = 200;
  localparam int LEN_DECODE  = 150;
  localparam int LEN_BP      = 250;
  localparam int LEN_PRIO    = 150;
  localparam int LEN_FLUSH   = 150;
  localparam int LEN_IDLE    = 40;
  localparam int CYCLE_LIMIT = 5 + LEN_ORDER + LEN_DECODE + LEN_BP + LEN_PRIO + LEN_FLUSH
                               + LEN_IDLE + 200;

  logic                               clk;
  logic                               rst_n;
  logic                               fetch_valid_i;
  logic [FETCH_W-1:0]                 fetch_lane_valid_i;
  logic [XLEN-1:0]                    fetch_pc_i;
  logic [FETCH_W-1:0][XLEN-1:0]       fetch_instr_i;
  logic                               fetch_ready_o;
  logic                               dec_ready_i;
  logic [DECODE_W-1:0]                dec_valid_o;
  logic [DECODE_W-1:0][XLEN-1:0]      dec_pc_o;
  class_e [DECODE_W-1:0]              dec_class_o;
  logic [DECODE_W-1:0][REG_W-1:0]     dec_src0_o;
  logic [DECODE_W-1:0][REG_W-1:0]     dec_src1_o;
  logic [DECODE_W-1:0][REG_W-1:0]     dec_dest_o;
  csr_op_e [DECODE_W-1:0]             dec_csr_op_o;
  logic [DECODE_W-1:0][CSR_NUM_W-1:0] dec_csr_num_o;
  logic                               cmt_valid_i;
  logic                               cmt_excp_i;
  logic                               cmt_tlbr_i;
  logic                               cmt_redirect_i;
  logic                               cmt_ertn_i;
  logic                               cmt_refetch_i;
  logic                               cmt_idle_i;
  logic [XLEN-1:0]                    cmt_pc_i;
  logic [XLEN-1:0]                    cmt_br_target_i;
  logic [XLEN-1:0]                    eentry_i;
  logic [XLEN-1:0]                    tlbrentry_i;
  logic [XLEN-1:0]                    era_i;
  logic                               has_int_i;
  logic                               flush_o;
  logic [XLEN-1:0]                    redirect_pc_o;
  logic                               fetch_enable_o;

  int   seed      = 86563;
  int   cycles    = 0;
  int   pass_cnt  = 0;
  int   fail_cnt  = 0;
  int   tb_errors = 0;
  int   errors;
  int   pending;
  logic stall_seen;

  frontend_top i_frontend_top (.*);

  tb_checker i_tb_checker (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_lane_valid_i (fetch_lane_valid_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_ready_i      (fetch_ready_o),
    .dec_ready_i        (dec_ready_i),
    .dec_valid_i        (dec_valid_o),
    .dec_pc_i           (dec_pc_o),
    .dec_class_i        (dec_class_o),
    .dec_src0_i         (dec_src0_o),
    .dec_src1_i         (dec_src1_o),
    .dec_dest_i         (dec_dest_o),
    .dec_csr_op_i       (dec_csr_op_o),
    .dec_csr_num_i      (dec_csr_num_o),
    .cmt_flags_i        ({cmt_valid_i, cmt_excp_i, cmt_tlbr_i, cmt_redirect_i, cmt_ertn_i,
                          cmt_refetch_i, cmt_idle_i}),
    .cmt_pc_i           (cmt_pc_i),
    .cmt_br_target_i    (cmt_br_target_i),
    .eentry_i           (eentry_i),
    .tlbrentry_i        (tlbrentry_i),
    .era_i              (era_i),
    .has_int_i          (has_int_i),
    .flush_i            (flush_o),
    .redirect_pc_i      (redirect_pc_o),
    .fetch_enable_i     (fetch_enable_o),
    .errors_o           (errors),
    .pending_o          (pending),
    .stall_seen_o       (stall_seen)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles before all tests finished", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==================================================
  // stimulus helpers
  // ==================================================
  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [XLEN-1:0] rand_instr();
    logic [XLEN-1:0] w;
    w = rand_word();
    case (rand_word() % 8)
      0: w[31:26] = OP_ALU_REG;
      1: w[31:26] = OP_ALU_IMM;
      2: w[31:26] = OP_BRANCH;
      3: w[31:26] = OP_BL;
      4: w[31:26] = OP_CSR;
      5: w[31:26] = OP_LOAD;
      6: w[31:26] = OP_STORE;
      default: w[31:26] = 6'b111111;
    endcase
    // bias rj towards the csr read and write encodings
    case (rand_word() % 4)
      0: w[9:5] = 5'd0;
      1: w[9:5] = 5'd1;
      default: ;
    endcase
    return w;
  endfunction

  task automatic clear_commit();
    cmt_valid_i    = 1'b0;
    cmt_excp_i     = 1'b0;
    cmt_tlbr_i     = 1'b0;
    cmt_redirect_i = 1'b0;
    cmt_ertn_i     = 1'b0;
    cmt_refetch_i  = 1'b0;
    cmt_idle_i     = 1'b0;
    has_int_i      = 1'b0;
  endtask

  // one commit in about every rate cycles, tlbr only together with excp
  task automatic drive_commit(input int rate);
    logic [31:0] r;
    r               = rand_word();
    cmt_valid_i     = (rand_word() % rate) == 0;
    cmt_excp_i      = r[0] & r[1];
    cmt_tlbr_i      = r[0] & r[1] & r[2];
    cmt_redirect_i  = r[3] & r[4];
    cmt_ertn_i      = r[5] & r[6];
    cmt_refetch_i   = r[7] & r[8];
    cmt_idle_i      = r[9] & r[10] & r[11];
    has_int_i       = r[12];
    cmt_pc_i        = rand_word() & 32'hffff_fffc;
    cmt_br_target_i = rand_word();
    eentry_i        = rand_word();
    tlbrentry_i     = rand_word();
    era_i           = rand_word();
  endtask

  task automatic drive_fetch(input bit full_mask);
    logic [31:0] r;
    r                  = rand_word();
    fetch_valid_i      = r[2:0] != 3'd0;
    fetch_lane_valid_i = full_mask ? '1 : r[3 +: FETCH_W];
    fetch_pc_i         = rand_word() & 32'hffff_fffc;
    for (int k = 0; k < FETCH_W; k++) begin
      fetch_instr_i[k] = rand_instr();
    end
  endtask

  task automatic run_phase(input int len, input bit full_mask, input int ready_pct,
                           input int cmt_rate);
    repeat (len) begin
      @(negedge clk);
      drive_fetch(full_mask);
      dec_ready_i = (rand_word() % 100) < ready_pct;
      if (cmt_rate > 0) begin
        drive_commit(cmt_rate);
      end
    end
  endtask

  // drain the buffer, then report the test
  task automatic finish_test(input string name, input int err_base);
    @(negedge clk);
    fetch_valid_i = 1'b0;
    dec_ready_i   = 1'b1;
    clear_commit();
    while (pending != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    if (errors + tb_errors == err_base) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail", name);
    end
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin : stimulus
    int base;
    clk                = 1'b0;
    rst_n              = 1'b0;
    fetch_valid_i      = 1'b0;
    fetch_lane_valid_i = '0;
    fetch_pc_i         = '0;
    fetch_instr_i      = '0;
    dec_ready_i        = 1'b0;
    cmt_pc_i           = '0;
    cmt_br_target_i    = '0;
    eentry_i           = '0;
    tlbrentry_i        = '0;
    era_i              = '0;
    clear_commit();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    base = errors + tb_errors;
    run_phase(LEN_ORDER, 1'b0, 100, 0);
    finish_test("compaction and order", base);

    base = errors + tb_errors;
    run_phase(LEN_DECODE, 1'b1, 100, 0);
    finish_test("decoding", base);

    base = errors + tb_errors;
    run_phase(LEN_BP, 1'b0, 25, 0);
    if (!stall_seen) begin
      $display("back-pressure never reached fetch, fetch_ready_o stayed high");
      tb_errors++;
    end
    finish_test("back-pressure", base);

    base = errors + tb_errors;
    run_phase(LEN_PRIO, 1'b0, 75, 2);
    finish_test("flush priority", base);

    base = errors + tb_errors;
    run_phase(LEN_FLUSH, 1'b0, 60, 8);
    finish_test("flush clearing", base);

    // idle without interrupt locks fetch, an interrupt releases it
    base = errors + tb_errors;
    @(negedge clk);
    cmt_valid_i = 1'b1;
    cmt_idle_i  = 1'b1;
    @(negedge clk);
    clear_commit();
    repeat (LEN_IDLE / 2) @(negedge clk);
    if (fetch_enable_o !== 1'b0) begin
      $display("Fail %0t ns: fetch_enable_o high while idle lock should hold", $time);
      tb_errors++;
    end
    has_int_i = 1'b1;
    @(negedge clk);
    cmt_valid_i = 1'b1;
    cmt_idle_i  = 1'b1;
    @(negedge clk);
    clear_commit();
    repeat (LEN_IDLE / 2) @(negedge clk);
    if (fetch_enable_o !== 1'b1) begin
      $display("Fail %0t ns: fetch_enable_o low after idle with interrupt pending", $time);
      tb_errors++;
    end
    finish_test("idle lock", base);

    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
source/frontend_pkg.sv
source/redirect_ctrl.sv
source/fetch_compactor.sv
source/instr_buffer.sv
source/instr_decoder.sv
source/frontend_top.sv
verification/tb_checker.sv
verification/tb_frontend.sv

// File: Makefile
# Verilator build and run of the front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
